//--- Makefile
# Verilator build and run for the scoreboarded core testbench

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/alu_unit.sv
`timescale 1ns/1ps

module alu_unit import core_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      dispatch,
	input  alu_op_t                   op,
	input  logic [data_width-1:0]     operand_a,
	input  logic [data_width-1:0]     operand_b,
	input  logic [reg_addr_width-1:0] dest,
	output logic                      wb_valid,
	output logic [reg_addr_width-1:0] wb_reg,
	output logic [data_width-1:0]     wb_value
);

	logic                      exec_valid;
	alu_op_t                   exec_op;
	logic [data_width-1:0]     exec_a;
	logic [data_width-1:0]     exec_b;
	logic [reg_addr_width-1:0] exec_dest;
	logic [data_width-1:0]     result;

	// Stage 1, capture operands on dispatch
	always_ff @(posedge clk) begin
		if (reset) begin
			exec_valid <= 1'b0;
		end else begin
			exec_valid <= dispatch;
		end
	end

	always_ff @(posedge clk) begin
		if (dispatch) begin
			exec_op <= op;
			exec_a <= operand_a;
			exec_b <= operand_b;
			exec_dest <= dest;
		end
	end

	assign result = (exec_op == alu_sub) ? exec_a - exec_b : exec_a + exec_b;

	// Stage 2, writeback register
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= exec_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (exec_valid) begin
			wb_reg <= exec_dest;
			wb_value <= result;
		end
	end

endmodule

//--- design/core_pkg.sv
package core_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths and counts
	////////////////////////////////////////////////////////////////////////////

	localparam int data_width = 16;
	localparam int instr_width = 16;
	localparam int reg_count = 8;
	localparam int reg_addr_width = 3;
	localparam int unit_count = 2;
	localparam int unit_id_width = 1;
	localparam int opcode_width = 5;
	localparam int imm_width = 5;

	// Instruction field positions
	localparam int opcode_msb = 15;
	localparam int opcode_lsb = 11;
	localparam int dest_msb = 10;
	localparam int dest_lsb = 8;
	localparam int src0_msb = 7;
	localparam int src0_lsb = 5;
	localparam int src1_msb = 2;
	localparam int src1_lsb = 0;
	localparam int imm_msb = 4;
	localparam int imm_lsb = 0;

	////////////////////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////////////////////

	// Anything outside these four decodes as a no-op
	typedef enum logic [opcode_width-1:0] {
		op_add_imm = 5'd0,
		op_add_reg = 5'd1,
		op_sub_imm = 5'd2,
		op_sub_reg = 5'd3
	} opcode_t;

	typedef enum logic {
		alu_add,
		alu_sub
	} alu_op_t;

	typedef enum logic [1:0] {
		st_idle,
		st_waiting,
		st_executing
	} station_state_t;

endpackage

//--- design/core_top.sv
`timescale 1ns/1ps

module core_top import core_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      instr_valid,
	input  logic [instr_width-1:0]    instr,
	output logic                      instr_ready,
	output logic                      wb0_valid,
	output logic [reg_addr_width-1:0] wb0_reg,
	output logic [data_width-1:0]     wb0_value,
	output logic                      wb1_valid,
	output logic [reg_addr_width-1:0] wb1_reg,
	output logic [data_width-1:0]     wb1_value,
	input  logic [reg_addr_width-1:0] dbg_addr,
	output logic [data_width-1:0]     dbg_value
);

	// Scoreboard to unit 0
	logic                      u0_dispatch;
	alu_op_t                   u0_op;
	logic [data_width-1:0]     u0_operand_a;
	logic [data_width-1:0]     u0_operand_b;
	logic [reg_addr_width-1:0] u0_dest;
	logic [reg_addr_width-1:0] u0_a_addr;
	logic [reg_addr_width-1:0] u0_b_addr;
	logic [data_width-1:0]     u0_a_value;
	logic [data_width-1:0]     u0_b_value;

	// Scoreboard to unit 1
	logic                      u1_dispatch;
	alu_op_t                   u1_op;
	logic [data_width-1:0]     u1_operand_a;
	logic [data_width-1:0]     u1_operand_b;
	logic [reg_addr_width-1:0] u1_dest;
	logic [reg_addr_width-1:0] u1_a_addr;
	logic [reg_addr_width-1:0] u1_b_addr;
	logic [data_width-1:0]     u1_a_value;
	logic [data_width-1:0]     u1_b_value;

	scoreboard scoreboard_inst (
		.clk          (clk),
		.reset        (reset),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.instr_ready  (instr_ready),
		.u0_dispatch  (u0_dispatch),
		.u0_op        (u0_op),
		.u0_operand_a (u0_operand_a),
		.u0_operand_b (u0_operand_b),
		.u0_dest      (u0_dest),
		.u0_a_addr    (u0_a_addr),
		.u0_b_addr    (u0_b_addr),
		.u0_a_value   (u0_a_value),
		.u0_b_value   (u0_b_value),
		.u1_dispatch  (u1_dispatch),
		.u1_op        (u1_op),
		.u1_operand_a (u1_operand_a),
		.u1_operand_b (u1_operand_b),
		.u1_dest      (u1_dest),
		.u1_a_addr    (u1_a_addr),
		.u1_b_addr    (u1_b_addr),
		.u1_a_value   (u1_a_value),
		.u1_b_value   (u1_b_value),
		.wb0_valid    (wb0_valid),
		.wb0_reg      (wb0_reg),
		.wb1_valid    (wb1_valid),
		.wb1_reg      (wb1_reg)
	);

	register_file register_file_inst (
		.clk        (clk),
		.reset      (reset),
		.wr0_en     (wb0_valid),
		.wr0_addr   (wb0_reg),
		.wr0_value  (wb0_value),
		.wr1_en     (wb1_valid),
		.wr1_addr   (wb1_reg),
		.wr1_value  (wb1_value),
		.u0_a_addr  (u0_a_addr),
		.u0_a_value (u0_a_value),
		.u0_b_addr  (u0_b_addr),
		.u0_b_value (u0_b_value),
		.u1_a_addr  (u1_a_addr),
		.u1_a_value (u1_a_value),
		.u1_b_addr  (u1_b_addr),
		.u1_b_value (u1_b_value),
		.dbg_addr   (dbg_addr),
		.dbg_value  (dbg_value)
	);

	alu_unit alu_unit_0 (
		.clk       (clk),
		.reset     (reset),
		.dispatch  (u0_dispatch),
		.op        (u0_op),
		.operand_a (u0_operand_a),
		.operand_b (u0_operand_b),
		.dest      (u0_dest),
		.wb_valid  (wb0_valid),
		.wb_reg    (wb0_reg),
		.wb_value  (wb0_value)
	);

	alu_unit alu_unit_1 (
		.clk       (clk),
		.reset     (reset),
		.dispatch  (u1_dispatch),
		.op        (u1_op),
		.operand_a (u1_operand_a),
		.operand_b (u1_operand_b),
		.dest      (u1_dest),
		.wb_valid  (wb1_valid),
		.wb_reg    (wb1_reg),
		.wb_value  (wb1_value)
	);

endmodule

//--- design/register_file.sv
`timescale 1ns/1ps

module register_file import core_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      wr0_en,
	input  logic [reg_addr_width-1:0] wr0_addr,
	input  logic [data_width-1:0]     wr0_value,
	input  logic                      wr1_en,
	input  logic [reg_addr_width-1:0] wr1_addr,
	input  logic [data_width-1:0]     wr1_value,
	input  logic [reg_addr_width-1:0] u0_a_addr,
	output logic [data_width-1:0]     u0_a_value,
	input  logic [reg_addr_width-1:0] u0_b_addr,
	output logic [data_width-1:0]     u0_b_value,
	input  logic [reg_addr_width-1:0] u1_a_addr,
	output logic [data_width-1:0]     u1_a_value,
	input  logic [reg_addr_width-1:0] u1_b_addr,
	output logic [data_width-1:0]     u1_b_value,
	input  logic [reg_addr_width-1:0] dbg_addr,
	output logic [data_width-1:0]     dbg_value
);

	logic [data_width-1:0] regs [reg_count];

	// Write addresses never collide, the scoreboard allows one producer per register
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else begin
			if (wr0_en) begin
				regs[wr0_addr] <= wr0_value;
			end
			if (wr1_en) begin
				regs[wr1_addr] <= wr1_value;
			end
		end
	end

	// Plain reads, a value written this cycle shows up next cycle
	assign u0_a_value = regs[u0_a_addr];
	assign u0_b_value = regs[u0_b_addr];
	assign u1_a_value = regs[u1_a_addr];
	assign u1_b_value = regs[u1_b_addr];
	assign dbg_value = regs[dbg_addr];

endmodule

//--- design/scoreboard.sv
`timescale 1ns/1ps

module scoreboard import core_pkg::*; (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      instr_valid,
	input  logic [instr_width-1:0]    instr,
	output logic                      instr_ready,
	output logic                      u0_dispatch,
	output alu_op_t                   u0_op,
	output logic [data_width-1:0]     u0_operand_a,
	output logic [data_width-1:0]     u0_operand_b,
	output logic [reg_addr_width-1:0] u0_dest,
	output logic [reg_addr_width-1:0] u0_a_addr,
	output logic [reg_addr_width-1:0] u0_b_addr,
	input  logic [data_width-1:0]     u0_a_value,
	input  logic [data_width-1:0]     u0_b_value,
	output logic                      u1_dispatch,
	output alu_op_t                   u1_op,
	output logic [data_width-1:0]     u1_operand_a,
	output logic [data_width-1:0]     u1_operand_b,
	output logic [reg_addr_width-1:0] u1_dest,
	output logic [reg_addr_width-1:0] u1_a_addr,
	output logic [reg_addr_width-1:0] u1_b_addr,
	input  logic [data_width-1:0]     u1_a_value,
	input  logic [data_width-1:0]     u1_b_value,
	input  logic                      wb0_valid,
	input  logic [reg_addr_width-1:0] wb0_reg,
	input  logic                      wb1_valid,
	input  logic [reg_addr_width-1:0] wb1_reg
);

	////////////////////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////////////////////

	opcode_t                   dec_opcode;
	logic                      dec_known;
	alu_op_t                   dec_op;
	logic                      dec_imm_flag;
	logic [reg_addr_width-1:0] dec_dest;
	logic [reg_addr_width-1:0] dec_src0;
	logic [reg_addr_width-1:0] dec_src1;
	logic [imm_width-1:0]      dec_imm;

	assign dec_opcode = opcode_t'(instr[opcode_msb:opcode_lsb]);
	assign dec_dest = instr[dest_msb:dest_lsb];
	assign dec_src0 = instr[src0_msb:src0_lsb];
	assign dec_src1 = instr[src1_msb:src1_lsb];
	assign dec_imm = instr[imm_msb:imm_lsb];

	always_comb begin
		dec_known = 1'b1;
		dec_op = alu_add;
		dec_imm_flag = 1'b0;
		case (dec_opcode)
			op_add_imm: begin
				dec_imm_flag = 1'b1;
			end
			op_add_reg: begin
				dec_imm_flag = 1'b0;
			end
			op_sub_imm: begin
				dec_op = alu_sub;
				dec_imm_flag = 1'b1;
			end
			op_sub_reg: begin
				dec_op = alu_sub;
			end
			default: begin
				dec_known = 1'b0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Stations and pending marks
	////////////////////////////////////////////////////////////////////////////

	logic                      started;
	station_state_t            st_state [unit_count];
	alu_op_t                   st_op [unit_count];
	logic [reg_addr_width-1:0] st_dest [unit_count];
	logic [reg_addr_width-1:0] st_src0 [unit_count];
	logic [reg_addr_width-1:0] st_src1 [unit_count];
	logic [imm_width-1:0]      st_imm [unit_count];
	logic                      st_imm_flag [unit_count];

	logic [reg_count-1:0]      pend_valid;
	logic [unit_id_width-1:0]  pend_unit [reg_count];

	logic                      wb_valid_arr [unit_count];
	logic [reg_addr_width-1:0] wb_reg_arr [unit_count];
	logic [data_width-1:0]     rd_a_value [unit_count];
	logic [data_width-1:0]     rd_b_value [unit_count];
	logic [data_width-1:0]     operand_b [unit_count];
	logic                      dispatch [unit_count];

	logic                      idle_any;
	logic [unit_id_width-1:0]  issue_unit;
	logic                      war_hit;
	logic                      alloc;

	assign wb_valid_arr[0] = wb0_valid;
	assign wb_valid_arr[1] = wb1_valid;
	assign wb_reg_arr[0] = wb0_reg;
	assign wb_reg_arr[1] = wb1_reg;
	assign rd_a_value[0] = u0_a_value;
	assign rd_a_value[1] = u1_a_value;
	assign rd_b_value[0] = u0_b_value;
	assign rd_b_value[1] = u1_b_value;

	// Lowest idle unit wins
	always_comb begin
		idle_any = 1'b0;
		issue_unit = '0;
		for (int i = unit_count - 1; i >= 0; i--) begin
			if (st_state[i] == st_idle) begin
				idle_any = 1'b1;
				issue_unit = unit_id_width'(i);
			end
		end
	end

	// A station that has not read its operands yet must not see them overwritten
	always_comb begin
		war_hit = 1'b0;
		for (int i = 0; i < unit_count; i++) begin
			if (st_state[i] == st_waiting && (st_src0[i] == dec_dest ||
					(!st_imm_flag[i] && st_src1[i] == dec_dest))) begin
				war_hit = 1'b1;
			end
		end
	end

	assign instr_ready = started && idle_any && !pend_valid[dec_dest] && !war_hit;
	assign alloc = instr_valid && instr_ready && dec_known;

	// A source marked by its own station is the old value, already committed
	always_comb begin
		for (int i = 0; i < unit_count; i++) begin
			dispatch[i] = (st_state[i] == st_waiting)
				&& (!pend_valid[st_src0[i]] || pend_unit[st_src0[i]] == unit_id_width'(i))
				&& (st_imm_flag[i] || !pend_valid[st_src1[i]]
					|| pend_unit[st_src1[i]] == unit_id_width'(i));
			operand_b[i] = st_imm_flag[i]
				? {{(data_width - imm_width){st_imm[i][imm_width-1]}}, st_imm[i]}
				: rd_b_value[i];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			started <= 1'b0;
			pend_valid <= '0;
			for (int i = 0; i < unit_count; i++) begin
				st_state[i] <= st_idle;
			end
		end else begin
			started <= 1'b1;
			for (int i = 0; i < unit_count; i++) begin
				if (dispatch[i]) begin
					st_state[i] <= st_executing;
				end
				if (wb_valid_arr[i]) begin
					st_state[i] <= st_idle;
					pend_valid[wb_reg_arr[i]] <= 1'b0;
				end
			end
			if (alloc) begin
				st_state[issue_unit] <= st_waiting;
				pend_valid[dec_dest] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (alloc) begin
			st_op[issue_unit] <= dec_op;
			st_dest[issue_unit] <= dec_dest;
			st_src0[issue_unit] <= dec_src0;
			st_src1[issue_unit] <= dec_src1;
			st_imm[issue_unit] <= dec_imm;
			st_imm_flag[issue_unit] <= dec_imm_flag;
			pend_unit[dec_dest] <= issue_unit;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Unit ports
	////////////////////////////////////////////////////////////////////////////

	assign u0_dispatch = dispatch[0];
	assign u0_op = st_op[0];
	assign u0_operand_a = rd_a_value[0];
	assign u0_operand_b = operand_b[0];
	assign u0_dest = st_dest[0];
	assign u0_a_addr = st_src0[0];
	assign u0_b_addr = st_src1[0];

	assign u1_dispatch = dispatch[1];
	assign u1_op = st_op[1];
	assign u1_operand_a = rd_a_value[1];
	assign u1_operand_b = operand_b[1];
	assign u1_dest = st_dest[1];
	assign u1_a_addr = st_src0[1];
	assign u1_b_addr = st_src1[1];

endmodule

//--- dv/core_assert.sv
`timescale 1ns/1ps

module core_assert (
	input  logic        clk,
	input  logic        reset,
	input  logic        instr_valid,
	input  logic        instr_ready,
	input  logic [15:0] instr,
	input  logic        wb0_valid,
	input  logic [2:0]  wb0_reg,
	input  logic        wb1_valid,
	input  logic [2:0]  wb1_reg
);

	// One producer per register
	assert property (@(posedge clk) disable iff (reset)
		wb0_valid && wb1_valid |-> wb0_reg != wb1_reg)
		else $error("both writebacks name r%0d in the same cycle", wb0_reg);

	assert property (@(posedge clk) reset |-> !instr_ready)
		else $error("instr_ready is high during reset");

	// Source must hold a stalled instruction
	assert property (@(posedge clk) disable iff (reset)
		instr_valid && !instr_ready |=> $stable(instr))
		else $error("instr changed while valid and not accepted");

endmodule

bind core_top core_assert core_assert_inst (
	.clk         (clk),
	.reset       (reset),
	.instr_valid (instr_valid),
	.instr_ready (instr_ready),
	.instr       (instr),
	.wb0_valid   (wb0_valid),
	.wb0_reg     (wb0_reg),
	.wb1_valid   (wb1_valid),
	.wb1_reg     (wb1_reg)
);

//--- dv/core_checker.sv
`timescale 1ns/1ps

module core_checker (
	input  logic            clk,
	input  logic            reset,
	input  logic            instr_valid,
	input  logic            instr_ready,
	input  logic [15:0]     instr,
	input  logic [8*24-1:0] test_name,
	input  logic [15:0]     test_expected,
	input  logic            wb0_valid,
	input  logic [2:0]      wb0_reg,
	input  logic [15:0]     wb0_value,
	input  logic            wb1_valid,
	input  logic [2:0]      wb1_reg,
	input  logic [15:0]     wb1_value,
	input  logic [2:0]      dbg_addr,
	input  logic [15:0]     dbg_value,
	input  logic            dbg_check,
	input  logic            final_check,
	output logic            busy,
	output int              pass_count,
	output int              error_count
);

	// Program-order model and one outstanding write per register
	logic [15:0]     model [8];
	logic [7:0]      outstanding = 8'h00;
	logic [7:0]      out_fixed;
	logic [15:0]     out_value [8];
	logic [15:0]     out_word [8];
	logic [8*24-1:0] out_name [8];
	int              out_cycle [8];
	// Set once an in-flight instruction has read its operands
	logic [7:0]      executing = 8'h00;
	logic [7:0]      sources_ready = 8'h00;
	int              unit_writes [2];
	int              passes = 0;
	int              errors = 0;
	int              cycle = 0;
	logic            reset_d = 1'b0;

	assign busy = |outstanding;
	assign pass_count = passes;
	assign error_count = errors;

	function automatic logic [15:0] execute(input logic [15:0] word);
		logic [15:0] a;
		logic [15:0] b;
		a = model[word[7:5]];
		b = word[11] ? model[word[2:0]] : {{11{word[4]}}, word[4:0]};
		return word[12] ? a - b : a + b;
	endfunction

	function automatic logic reads_reg(input logic [15:0] word, input logic [2:0] r);
		return word[7:5] == r || (word[11] && word[2:0] == r);
	endfunction

	// A source equal to its own destination holds the committed old value
	function automatic logic operands_free(input logic [15:0] word, input logic [2:0] rd);
		logic a_free;
		logic b_free;
		a_free = word[7:5] == rd || !outstanding[word[7:5]];
		b_free = !word[11] || word[2:0] == rd || !outstanding[word[2:0]];
		return a_free && b_free;
	endfunction

	task automatic check_writeback(input int unit, input logic [2:0] rd,
			input logic [15:0] value);
		if (!outstanding[rd]) begin
			$display("ERROR unit %0d wrote r%0d with no instruction outstanding for it",
				unit, rd);
			errors++;
		end else begin
			if (value !== out_value[rd]) begin
				$display("FAILED %0s expected 0x%04h actual 0x%04h", out_name[rd],
					out_value[rd], value);
				errors++;
			end else if (out_fixed[rd] && cycle - out_cycle[rd] != 3) begin
				$display("ERROR %0s wrote back %0d cycles after issue instead of 3",
					out_name[rd], cycle - out_cycle[rd]);
				errors++;
			end else begin
				$display("PASSED %0s r%0d = 0x%04h on unit %0d", out_name[rd], rd, value, unit);
				passes++;
			end
			outstanding[rd] = 1'b0;
			unit_writes[unit]++;
		end
	endtask

	task automatic accept_instr();
		logic [2:0]  rd;
		logic [15:0] result;
		logic        imm_form;
		rd = instr[10:8];
		imm_form = !instr[11];
		if (outstanding[rd]) begin
			$display("ERROR %0s accepted while r%0d still had a write in flight",
				test_name, rd);
			errors++;
		end
		for (int r = 0; r < 8; r++) begin
			if (outstanding[r] && !executing[r] && reads_reg(out_word[r], rd)) begin
				$display("ERROR %0s accepted while %0s still waits to read r%0d",
					test_name, out_name[r], rd);
				errors++;
			end
		end
		if (instr[15:11] > 5'd3) begin
			if (test_expected !== model[rd]) begin
				$display("ERROR %0s table value 0x%04h disagrees with unchanged r%0d 0x%04h",
					test_name, test_expected, rd, model[rd]);
				errors++;
			end else begin
				$display("PASSED %0s accepted as a no-op", test_name);
				passes++;
			end
		end else begin
			result = execute(instr);
			if (result !== test_expected) begin
				$display("ERROR %0s table value 0x%04h disagrees with in-order result 0x%04h",
					test_name, test_expected, result);
				errors++;
			end
			out_fixed[rd] = !outstanding[instr[7:5]] && (imm_form || !outstanding[instr[2:0]]);
			model[rd] = result;
			outstanding[rd] = 1'b1;
			executing[rd] = 1'b0;
			out_value[rd] = result;
			out_word[rd] = instr;
			out_name[rd] = test_name;
			out_cycle[rd] = cycle;
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			for (int r = 0; r < 8; r++) begin
				model[r] = 16'h0000;
			end
			outstanding = 8'h00;
			executing = 8'h00;
			sources_ready = 8'h00;
			unit_writes[0] = 0;
			unit_writes[1] = 0;
		end
		if ((reset || reset_d) && (instr_ready || wb0_valid || wb1_valid)) begin
			$display("ERROR instr_ready or a writeback valid is high during or just after reset");
			errors++;
		end
		if (!reset && wb0_valid) begin
			check_writeback(0, wb0_reg, wb0_value);
		end
		if (!reset && wb1_valid) begin
			check_writeback(1, wb1_reg, wb1_value);
		end
		if (!reset && instr_valid && instr_ready) begin
			accept_instr();
		end
		// Operands were read in the cycle before this edge
		executing = executing | sources_ready;
		for (int r = 0; r < 8; r++) begin
			sources_ready[r] = outstanding[r] && !executing[r]
				&& operands_free(out_word[r], 3'(r));
		end
		if (dbg_check) begin
			if (dbg_value !== model[dbg_addr]) begin
				$display("FAILED debug_r%0d expected 0x%04h actual 0x%04h", dbg_addr,
					model[dbg_addr], dbg_value);
				errors++;
			end else begin
				$display("PASSED debug_r%0d = 0x%04h", dbg_addr, dbg_value);
				passes++;
			end
		end
		if (final_check) begin
			if (outstanding != 8'h00) begin
				$display("ERROR writes still outstanding after the core drained");
				errors++;
			end
			if (unit_writes[0] == 0 || unit_writes[1] == 0) begin
				$display("ERROR one of the two units never wrote back");
				errors++;
			end
		end
		reset_d = reset;
		cycle++;
	end

endmodule

//--- dv/core_tb.sv
`timescale 1ns/1ps

module core_tb;

	localparam int clk_period = 4;
	localparam int seed = 58738;
	localparam int row_count = 19;
	localparam int timeout_margin = 100;
	localparam int timeout_cycles = row_count * 12 + timeout_margin;

	logic              clk = 1'b0;
	logic              reset;
	logic              instr_valid;
	logic [15:0]       instr;
	logic              instr_ready;
	logic              wb0_valid;
	logic [2:0]        wb0_reg;
	logic [15:0]       wb0_value;
	logic              wb1_valid;
	logic [2:0]        wb1_reg;
	logic [15:0]       wb1_value;
	logic [2:0]        dbg_addr;
	logic [15:0]       dbg_value;
	logic              dbg_check;
	logic              final_check;
	logic [8*24-1:0]   test_name;
	logic [15:0]       test_expected;
	logic              busy;
	int                pass_count;
	int                error_count;
	int                cycle_count = 0;
	int                rows_loaded = 0;

	// Stimulus table, expected values from in-order execution on zeroed registers
	logic [8*24-1:0]   row_name [row_count];
	logic [15:0]       row_instr [row_count];
	logic [15:0]       row_expected [row_count];
	logic              row_no_gap [row_count];

	always #(clk_period / 2) clk = ~clk;

	core_top core_top_inst (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.instr_ready (instr_ready),
		.wb0_valid   (wb0_valid),
		.wb0_reg     (wb0_reg),
		.wb0_value   (wb0_value),
		.wb1_valid   (wb1_valid),
		.wb1_reg     (wb1_reg),
		.wb1_value   (wb1_value),
		.dbg_addr    (dbg_addr),
		.dbg_value   (dbg_value)
	);

	core_checker core_checker_inst (
		.clk           (clk),
		.reset         (reset),
		.instr_valid   (instr_valid),
		.instr_ready   (instr_ready),
		.instr         (instr),
		.test_name     (test_name),
		.test_expected (test_expected),
		.wb0_valid     (wb0_valid),
		.wb0_reg       (wb0_reg),
		.wb0_value     (wb0_value),
		.wb1_valid     (wb1_valid),
		.wb1_reg       (wb1_reg),
		.wb1_value     (wb1_value),
		.dbg_addr      (dbg_addr),
		.dbg_value     (dbg_value),
		.dbg_check     (dbg_check),
		.final_check   (final_check),
		.busy          (busy),
		.pass_count    (pass_count),
		.error_count   (error_count)
	);

	////////////////////////////////////////////////////////////////////////////
	// Table
	////////////////////////////////////////////////////////////////////////////

	task automatic add_row(input logic [8*24-1:0] name, input logic [4:0] op,
			input logic [2:0] dest, input logic [2:0] src0, input logic [4:0] low,
			input logic [15:0] expected, input logic no_gap);
		row_name[rows_loaded] = name;
		row_instr[rows_loaded] = {op, dest, src0, low};
		row_expected[rows_loaded] = expected;
		row_no_gap[rows_loaded] = no_gap;
		rows_loaded++;
	endtask

	task automatic fill_table();
		add_row("addi_r1_5", 5'd0, 3'd1, 3'd0, 5'h05, 16'h0005, 1'b0);
		add_row("addi_r2_neg3", 5'd0, 3'd2, 3'd0, 5'h1d, 16'hfffd, 1'b1);
		add_row("subi_r3_r1_neg16", 5'd2, 3'd3, 3'd1, 5'h10, 16'h0015, 1'b0);
		add_row("subi_r4_r2_7", 5'd2, 3'd4, 3'd2, 5'h07, 16'hfff6, 1'b1);
		add_row("addi_r5_r1_15", 5'd0, 3'd5, 3'd1, 5'h0f, 16'h0014, 1'b0);
		// Register forms, read after write chain
		add_row("addr_r6_r1_r3", 5'd1, 3'd6, 3'd1, 5'd3, 16'h001a, 1'b0);
		add_row("subr_r7_r6_r2", 5'd3, 3'd7, 3'd6, 5'd2, 16'h001d, 1'b1);
		add_row("addr_r1_r7_r7", 5'd1, 3'd1, 3'd7, 5'd7, 16'h003a, 1'b1);
		add_row("subr_r0_r1_r4", 5'd3, 3'd0, 3'd1, 5'd4, 16'h0044, 1'b0);
		add_row("addi_r2_r5_1", 5'd0, 3'd2, 3'd5, 5'h01, 16'h0015, 1'b0);
		add_row("addi_r3_r5_2", 5'd0, 3'd3, 3'd5, 5'h02, 16'h0016, 1'b1);
		// Same destination back to back, then a reader of a pending source
		add_row("waw_addi_r4_r0_9", 5'd0, 3'd4, 3'd0, 5'h09, 16'h004d, 1'b0);
		add_row("waw_subi_r4_r4_1", 5'd2, 3'd4, 3'd4, 5'h01, 16'h004c, 1'b1);
		add_row("addi_r5_r4_neg1", 5'd0, 3'd5, 3'd4, 5'h1f, 16'h004b, 1'b0);
		add_row("war_addr_r6_r5_r2", 5'd1, 3'd6, 3'd5, 5'd2, 16'h0060, 1'b1);
		add_row("war_subi_r2_r3_3", 5'd2, 3'd2, 3'd3, 5'h03, 16'h0013, 1'b1);
		add_row("noop_op31_r1", 5'd31, 3'd1, 3'd1, 5'h00, 16'h003a, 1'b0);
		add_row("subr_r0_r0_r0", 5'd3, 3'd0, 3'd0, 5'd0, 16'h0000, 1'b0);
		add_row("addi_r7_r7_neg1", 5'd0, 3'd7, 3'd7, 5'h1f, 16'h001c, 1'b0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Driving
	////////////////////////////////////////////////////////////////////////////

	task automatic send_row(input int idx);
		logic taken;
		instr_valid = 1'b1;
		instr = row_instr[idx];
		test_name = row_name[idx];
		test_expected = row_expected[idx];
		taken = 1'b0;
		while (!taken) begin
			@(posedge clk);
			taken = instr_ready;
			@(negedge clk);
		end
		instr_valid = 1'b0;
	endtask

	task automatic read_all_registers();
		for (int r = 0; r < 8; r++) begin
			dbg_addr = 3'(r);
			dbg_check = 1'b1;
			@(negedge clk);
		end
		dbg_check = 1'b0;
	endtask

	initial begin
		int gap;
		void'($urandom(seed));
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = 16'h0000;
		dbg_addr = 3'd0;
		dbg_check = 1'b0;
		final_check = 1'b0;
		test_name = '0;
		test_expected = 16'h0000;
		fill_table();
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		read_all_registers();
		for (int i = 0; i < row_count; i++) begin
			if (!row_no_gap[i]) begin
				gap = $urandom_range(3, 0);
				repeat (gap) @(negedge clk);
			end
			send_row(i);
		end
		// Drain both units
		while (busy) begin
			@(negedge clk);
		end
		read_all_registers();
		final_check = 1'b1;
		@(negedge clk);
		final_check = 1'b0;
		@(negedge clk);
		$display("Checks passed: %0d, failed: %0d", pass_count, error_count);
		if (error_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the core did not finish within %0d cycles", timeout_cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

endmodule

//--- sim.f
design/core_pkg.sv
design/register_file.sv
design/alu_unit.sv
design/scoreboard.sv
design/core_top.sv
dv/core_assert.sv
dv/core_checker.sv
dv/core_tb.sv
